// ==== logic/am_rx_cfg.svh ====
// build-time sizing for the AM receiver; include it wherever channel count or latency bound is needed.
`ifndef AM_RX_CFG_SVH
`define AM_RX_CFG_SVH

// --------------------------------------------------
// channel sizing
// --------------------------------------------------

// number of demodulator channels.
`define AM_NUM_CHAN 4

// bits needed to name one channel.
`define AM_CHAN_W 2

// worst case clocks from a load tick to the matching done tick.
`define AM_MAX_LATENCY 64

`endif

// ==== logic/am_rx_pkg.sv ====
// shared sample, result and state types for the AM receiver; import into any block that uses them.
`include "am_rx_cfg.svh"

package am_rx_pkg;

	// signed I or Q sample.
	typedef logic signed [7:0] sample_t;

	// root in the upper byte, lower byte always zero.
	typedef logic signed [15:0] demod_t;

	// channel tag carried with samples and results.
	typedef logic [`AM_CHAN_W-1:0] chan_t;

	// --------------------------------------------------
	// demodulator sequencing
	// --------------------------------------------------

	typedef enum logic [2:0] {
		st_idle,
		st_start_mult_i,
		st_multiply_i,
		st_start_mult_q,
		st_multiply_q,
		st_start_sqrt,
		st_wait_sqrt
	} mult_state_t;

	typedef enum logic [1:0] {
		sq_wait,
		sq_setup,
		sq_iterate,
		sq_finish
	} sqrt_phase_t;

endpackage

// ==== logic/iq_dispatch.sv ====
// steers each tagged I/Q pair to its demodulator, holds the pair until done and counts drops.
`timescale 1ns/1ps
`include "am_rx_cfg.svh"

module iq_dispatch import am_rx_pkg::*; #(
	parameter int NUM_CHAN = `AM_NUM_CHAN
) (
	input  logic                CLK,
	input  logic                RSTb,
	input  logic                iq_valid,
	input  chan_t               iq_chan,
	input  sample_t             i_data,
	input  sample_t             q_data,
	input  logic [NUM_CHAN-1:0] done_tick,
	output logic [NUM_CHAN-1:0] load_tick,
	output sample_t             i_hold [NUM_CHAN],
	output sample_t             q_hold [NUM_CHAN],
	output logic [15:0]         drop_count
);

	logic [NUM_CHAN-1:0] busy;
	logic                chan_ok;
	logic                accept;

	// tags past the last channel have nowhere to go.
	assign chan_ok = (int'(iq_chan) < NUM_CHAN);
	assign accept  = iq_valid && chan_ok && !busy[iq_chan];

	// --------------------------------------------------
	// busy tracking and drop counter
	// --------------------------------------------------

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			busy       <= '0;
			load_tick  <= '0;
			drop_count <= '0;
		end else begin
			load_tick <= '0;
			// a finished channel frees up one cycle after its done tick.
			busy <= busy & ~done_tick;
			if (accept) begin
				load_tick[iq_chan] <= 1'b1;
				busy[iq_chan]      <= 1'b1;
			end else if (iq_valid && drop_count != 16'hffff) begin
				drop_count <= drop_count + 16'd1;
			end
		end
	end

	// pair stays put while the channel works on it.
	always_ff @(posedge CLK) begin
		if (accept) begin
			i_hold[iq_chan] <= i_data;
			q_hold[iq_chan] <= q_data;
		end
	end

	// only one channel can start per clock.
	a_one_load: assert property (@(posedge CLK) disable iff (!RSTb)
		$onehot0(load_tick));

endmodule

// ==== logic/am_demod_lite.sv ====
// per-channel AM envelope stage: squares I and Q, halves the sum and takes its square root.
`timescale 1ns/1ps
`include "am_rx_cfg.svh"

module am_demod_lite import am_rx_pkg::*; (
	input  logic    CLK,
	input  logic    RSTb,
	input  sample_t i_in,
	input  sample_t q_in,
	input  logic    load_tick,
	output demod_t  demod_out,
	output logic    out_tick
);

	localparam int LAT_W = $clog2(`AM_MAX_LATENCY) + 1;

	mult_state_t        state;
	logic [2:0]         m_count;
	logic signed [16:0] mult_a;
	logic [7:0]         mult_b;
	logic [16:0]        sum;

	sqrt_phase_t        sq_phase;
	logic [1:0]         step;
	logic [2:0]         iter;
	logic               sqrt_done;
	logic [15:0]        rad;
	logic [7:0]         root;
	logic [9:0]         left;
	logic [9:0]         right;
	logic [9:0]         rem;

	logic [LAT_W-1:0]   lat_cnt;

	// --------------------------------------------------
	// shift-add squaring of I then Q
	// --------------------------------------------------

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state   <= st_idle;
			m_count <= '0;
		end else begin
			case (state)
				st_idle:
					if (load_tick)
						state <= st_start_mult_i;
				st_start_mult_i: begin
					m_count <= '0;
					state   <= st_multiply_i;
				end
				st_multiply_i: begin
					m_count <= m_count + 3'd1;
					if (m_count == 3'd7)
						state <= st_start_mult_q;
				end
				st_start_mult_q: begin
					m_count <= '0;
					state   <= st_multiply_q;
				end
				st_multiply_q: begin
					m_count <= m_count + 3'd1;
					if (m_count == 3'd7)
						state <= st_start_sqrt;
				end
				st_start_sqrt:
					state <= st_wait_sqrt;
				st_wait_sqrt:
					if (sqrt_done)
						state <= st_idle;
				default:
					state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		case (state)
			st_idle:
				if (load_tick)
					sum <= '0;
			st_start_mult_i: begin
				mult_a <= {{9{i_in[7]}}, i_in};
				mult_b <= i_in;
			end
			st_start_mult_q: begin
				mult_a <= {{9{q_in[7]}}, q_in};
				mult_b <= q_in;
			end
			st_multiply_i, st_multiply_q: begin
				// bit 7 carries negative weight in two's complement.
				if (mult_b[0]) begin
					if (m_count == 3'd7)
						sum <= sum - $unsigned(mult_a);
					else
						sum <= sum + $unsigned(mult_a);
				end
				mult_a <= mult_a <<< 1;
				mult_b <= mult_b >> 1;
			end
			default: ;
		endcase
	end

	// --------------------------------------------------
	// non-restoring square root, three clocks per bit
	// --------------------------------------------------

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			sq_phase  <= sq_wait;
			step      <= '0;
			iter      <= '0;
			out_tick  <= 1'b0;
			sqrt_done <= 1'b0;
		end else begin
			out_tick  <= 1'b0;
			sqrt_done <= 1'b0;
			case (sq_phase)
				sq_wait:
					if (state == st_start_sqrt)
						sq_phase <= sq_setup;
				sq_setup: begin
					step     <= '0;
					iter     <= '0;
					sq_phase <= sq_iterate;
				end
				sq_iterate: begin
					if (step == 2'd2) begin
						step <= '0;
						iter <= iter + 3'd1;
						if (iter == 3'd7)
							sq_phase <= sq_finish;
					end else begin
						step <= step + 2'd1;
					end
				end
				sq_finish: begin
					out_tick  <= 1'b1;
					sqrt_done <= 1'b1;
					sq_phase  <= sq_wait;
				end
				default:
					sq_phase <= sq_wait;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		case (sq_phase)
			sq_setup: begin
				// half the power, so the root is the rms of the pair.
				rad   <= sum[16:1];
				left  <= '0;
				right <= '0;
				rem   <= '0;
				root  <= '0;
			end
			sq_iterate: begin
				case (step)
					2'd0: begin
						right <= {root, rem[9], 1'b1};
						left  <= {rem[7:0], rad[15:14]};
						rad   <= {rad[13:0], 2'b00};
					end
					2'd1: begin
						// negative remainder means add back this time.
						if (rem[9])
							rem <= left + right;
						else
							rem <= left - right;
					end
					2'd2:
						root <= {root[6:0], ~rem[9]};
					default: ;
				endcase
			end
			sq_finish:
				demod_out <= {root, 8'd0};
			default: ;
		endcase
	end

	// --------------------------------------------------
	// latency watch
	// --------------------------------------------------

	always_ff @(posedge CLK) begin
		if (!RSTb)
			lat_cnt <= '0;
		else if (out_tick)
			lat_cnt <= '0;
		else if (load_tick || lat_cnt != '0)
			lat_cnt <= lat_cnt + 1'b1;
	end

	// the dispatcher must not reload a channel that is still working.
	a_load_idle: assert property (@(posedge CLK) disable iff (!RSTb)
		load_tick |-> state == st_idle);

	a_latency: assert property (@(posedge CLK) disable iff (!RSTb)
		lat_cnt <= LAT_W'(`AM_MAX_LATENCY));

endmodule

// ==== logic/demod_collector.sv ====
// gathers finished channel results and sends them out one per cycle in round-robin order.
`timescale 1ns/1ps
`include "am_rx_cfg.svh"

module demod_collector import am_rx_pkg::*; #(
	parameter int NUM_CHAN = `AM_NUM_CHAN
) (
	input  logic                CLK,
	input  logic                RSTb,
	input  logic [NUM_CHAN-1:0] done_tick,
	input  demod_t              demod_in [NUM_CHAN],
	output logic                out_valid,
	output chan_t               out_chan,
	output demod_t              out_data
);

	demod_t              res [NUM_CHAN];
	logic [NUM_CHAN-1:0] pending;
	logic [NUM_CHAN-1:0] pick_mask;
	logic                pick_valid;
	chan_t               pick;
	chan_t               last;

	// --------------------------------------------------
	// next pending channel after the last one served
	// --------------------------------------------------

	always_comb begin
		int idx;
		pick_valid = 1'b0;
		pick       = last;
		pick_mask  = '0;
		for (int k = 1; k <= NUM_CHAN; k++) begin
			idx = (int'(last) + k) % NUM_CHAN;
			if (!pick_valid && pending[idx]) begin
				pick_valid     = 1'b1;
				pick           = chan_t'(idx);
				pick_mask[idx] = 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pending   <= '0;
			out_valid <= 1'b0;
			// start just before channel 0.
			last      <= chan_t'(NUM_CHAN - 1);
		end else begin
			out_valid <= pick_valid;
			pending   <= (pending & ~pick_mask) | done_tick;
			if (pick_valid)
				last <= pick;
		end
	end

	always_ff @(posedge CLK) begin
		for (int k = 0; k < NUM_CHAN; k++) begin
			if (done_tick[k])
				res[k] <= demod_in[k];
		end
		if (pick_valid) begin
			out_chan <= pick;
			out_data <= res[pick];
		end
	end

	// one slot per channel; a second result before draining would be lost.
	a_no_overrun: assert property (@(posedge CLK) disable iff (!RSTb)
		(done_tick & pending) == '0);

endmodule

// ==== logic/am_rx_top.sv ====
// multi-channel AM envelope receiver: dispatcher, per-channel demodulators and result collector.
`timescale 1ns/1ps
`include "am_rx_cfg.svh"

module am_rx_top import am_rx_pkg::*; #(
	parameter int NUM_CHAN = `AM_NUM_CHAN
) (
	input  logic        CLK,
	input  logic        RSTb,
	input  logic        iq_valid,
	input  chan_t       iq_chan,
	input  sample_t     i_data,
	input  sample_t     q_data,
	output logic        out_valid,
	output chan_t       out_chan,
	output demod_t      out_data,
	output logic [15:0] drop_count
);

	logic [NUM_CHAN-1:0] load_tick;
	logic [NUM_CHAN-1:0] done_tick;
	sample_t             i_hold [NUM_CHAN];
	sample_t             q_hold [NUM_CHAN];
	demod_t              demod  [NUM_CHAN];

	iq_dispatch #(.NUM_CHAN(NUM_CHAN)) iq_dispatch_inst (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.iq_valid   (iq_valid),
		.iq_chan    (iq_chan),
		.i_data     (i_data),
		.q_data     (q_data),
		.done_tick  (done_tick),
		.load_tick  (load_tick),
		.i_hold     (i_hold),
		.q_hold     (q_hold),
		.drop_count (drop_count)
	);

	// one demodulator per channel.
	for (genvar g = 0; g < NUM_CHAN; g++) begin : g_chan
		am_demod_lite am_demod_lite_inst (
			.CLK       (CLK),
			.RSTb      (RSTb),
			.i_in      (i_hold[g]),
			.q_in      (q_hold[g]),
			.load_tick (load_tick[g]),
			.demod_out (demod[g]),
			.out_tick  (done_tick[g])
		);
	end

	demod_collector #(.NUM_CHAN(NUM_CHAN)) demod_collector_inst (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.done_tick (done_tick),
		.demod_in  (demod),
		.out_valid (out_valid),
		.out_chan  (out_chan),
		.out_data  (out_data)
	);

endmodule

// ==== tb/am_rx_tb.sv ====
// self-checking testbench for the AM receiver; compile with the file list and run am_rx_tb as top.
`timescale 1ns/1ps
`include "am_rx_cfg.svh"

module am_rx_tb import am_rx_pkg::*; ();

	localparam int RANDOM_PAIRS = 400;
	localparam int BURSTS       = 20;
	localparam int TOTAL_PAIRS  = 5 + RANDOM_PAIRS + 4 * BURSTS + 4;
	localparam int WATCH_CYCLES = TOTAL_PAIRS * (`AM_MAX_LATENCY + 8) + 200;

	logic        CLK;
	logic        RSTb;
	logic        iq_valid;
	chan_t       iq_chan;
	sample_t     i_data;
	sample_t     q_data;
	logic        out_valid;
	chan_t       out_chan;
	demod_t      out_data;
	logic [15:0] drop_count;

	// expected results still owed by each channel.
	demod_t      exp_q [`AM_NUM_CHAN][$];
	// every result seen per channel, owed or not.
	int          got_count [`AM_NUM_CHAN];
	logic [15:0] exp_drops;
	int          n_checks;
	int          n_errors;
	int          n_tests;
	int          test_base;
	string       test_name;

	am_rx_top am_rx_top_inst (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.iq_valid   (iq_valid),
		.iq_chan    (iq_chan),
		.i_data     (i_data),
		.q_data     (q_data),
		.out_valid  (out_valid),
		.out_chan   (out_chan),
		.out_data   (out_data),
		.drop_count (drop_count)
	);

	always #50 CLK = ~CLK;

	// --------------------------------------------------
	// reference model and compare tasks
	// --------------------------------------------------

	// floor of the square root of half the power, placed in the upper byte.
	function automatic demod_t expected_mag(input sample_t i_v, input sample_t q_v);
		int power;
		int half;
		int r;
		power = int'(i_v) * int'(i_v) + int'(q_v) * int'(q_v);
		half  = power / 2;
		r     = 0;
		while ((r + 1) * (r + 1) <= half)
			r++;
		return demod_t'({r[7:0], 8'h00});
	endfunction

	task automatic check_demod(input chan_t ch, input demod_t exp_v, input demod_t got_v);
		n_checks++;
		if (got_v !== exp_v) begin
			n_errors++;
			$display("FAILED out_data on channel %0d: expected %h, got %h", ch, exp_v, got_v);
		end
	endtask

	task automatic check_chan(input chan_t ch, output bit ok);
		n_checks++;
		ok = (exp_q[ch].size() != 0);
		if (!ok) begin
			n_errors++;
			$display("result arrived on channel %0d with no pair outstanding", ch);
		end
	endtask

	task automatic check_count(input logic [15:0] exp_v, input logic [15:0] got_v);
		n_checks++;
		if (got_v !== exp_v) begin
			n_errors++;
			$display("FAILED drop_count: expected %h, got %h", exp_v, got_v);
		end
	endtask

	// outputs settle after the rising edge, so look at them on the falling one.
	always @(negedge CLK) begin
		bit ok;
		if (RSTb === 1'b1 && out_valid === 1'b1) begin
			got_count[out_chan]++;
			check_chan(out_chan, ok);
			if (ok)
				check_demod(out_chan, exp_q[out_chan].pop_front(), out_data);
		end
	end

	// --------------------------------------------------
	// stimulus helpers
	// --------------------------------------------------

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge CLK);
			#1;
			iq_valid = 1'b0;
		end
	endtask

	// a pair to a channel still owing a result is a drop, as in the dispatcher.
	task automatic drive_pair(input chan_t ch, input sample_t i_v, input sample_t q_v);
		@(posedge CLK);
		#1;
		iq_valid = 1'b1;
		iq_chan  = ch;
		i_data   = i_v;
		q_data   = q_v;
		if (exp_q[ch].size() != 0) begin
			if (exp_drops != 16'hffff)
				exp_drops = exp_drops + 16'd1;
		end else begin
			exp_q[ch].push_back(expected_mag(i_v, q_v));
		end
	endtask

	task automatic wait_chan_idle(input chan_t ch);
		while (exp_q[ch].size() != 0)
			idle_cycles(1);
	endtask

	task automatic wait_all_idle();
		for (int c = 0; c < `AM_NUM_CHAN; c++)
			wait_chan_idle(chan_t'(c));
	endtask

	task automatic send_corner(input sample_t i_v, input sample_t q_v);
		drive_pair(chan_t'(0), i_v, q_v);
		idle_cycles(1);
		wait_chan_idle(chan_t'(0));
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_base = n_errors;
		n_tests++;
	endtask

	task automatic finish_test();
		if (n_errors == test_base)
			$display("test %0d %s: ok", n_tests, test_name);
		else
			$display("test %0d %s: %0d errors", n_tests, test_name, n_errors - test_base);
	endtask

	// --------------------------------------------------
	// watchdog
	// --------------------------------------------------

	initial begin
		repeat (WATCH_CYCLES) @(posedge CLK);
		$display("watchdog expired after %0d cycles, results never arrived", WATCH_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------

	initial begin
		chan_t ch;
		chan_t other;
		int    base [`AM_NUM_CHAN];
		CLK       = 1'b0;
		RSTb      = 1'b0;
		iq_valid  = 1'b0;
		iq_chan   = '0;
		i_data    = '0;
		q_data    = '0;
		exp_drops = '0;
		n_checks  = 0;
		n_errors  = 0;
		n_tests   = 0;
		for (int c = 0; c < `AM_NUM_CHAN; c++)
			got_count[c] = 0;
		void'($urandom(32'hab2c21ff));
		repeat (3) @(posedge CLK);
		#1;
		RSTb = 1'b1;

		start_test("idle after reset");
		for (int n = 0; n < 20; n++) begin
			idle_cycles(1);
			check_count(16'd0, drop_count);
		end
		finish_test();

		start_test("corner pairs");
		send_corner(8'h00, 8'h00);
		send_corner(8'h7f, 8'h00);
		send_corner(8'h80, 8'h80);
		send_corner(8'h80, 8'h7f);
		send_corner(8'h01, 8'hff);
		finish_test();

		start_test("random pairs");
		for (int n = 0; n < RANDOM_PAIRS; n++) begin
			ch = chan_t'($urandom_range(0, `AM_NUM_CHAN - 1));
			wait_chan_idle(ch);
			drive_pair(ch, sample_t'($urandom()), sample_t'($urandom()));
			idle_cycles($urandom_range(0, 3));
		end
		idle_cycles(1);
		wait_all_idle();
		check_count(exp_drops, drop_count);
		finish_test();

		// the repeats land within three cycles of the first load, well inside the busy time.
		start_test("busy drops");
		for (int n = 0; n < BURSTS; n++) begin
			wait_all_idle();
			ch    = chan_t'($urandom_range(0, `AM_NUM_CHAN - 1));
			other = chan_t'(ch + $urandom_range(1, `AM_NUM_CHAN - 1));
			drive_pair(ch, sample_t'($urandom()), sample_t'($urandom()));
			drive_pair(ch, sample_t'($urandom()), sample_t'($urandom()));
			drive_pair(other, sample_t'($urandom()), sample_t'($urandom()));
			drive_pair(ch, sample_t'($urandom()), sample_t'($urandom()));
			idle_cycles(1);
		end
		wait_all_idle();
		idle_cycles(2 * `AM_MAX_LATENCY);
		check_count(exp_drops, drop_count);
		finish_test();

		start_test("all channels back to back");
		wait_all_idle();
		for (int c = 0; c < `AM_NUM_CHAN; c++)
			base[c] = got_count[c];
		for (int c = 0; c < `AM_NUM_CHAN; c++)
			drive_pair(chan_t'(c), sample_t'($urandom()), sample_t'($urandom()));
		idle_cycles(1);
		wait_all_idle();
		idle_cycles(`AM_NUM_CHAN + 2);
		for (int c = 0; c < `AM_NUM_CHAN; c++) begin
			n_checks++;
			if (got_count[c] != base[c] + 1) begin
				n_errors++;
				$display("channel %0d gave %0d results for one load", c, got_count[c] - base[c]);
			end
		end
		check_count(exp_drops, drop_count);
		finish_test();

		$display("summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
		if (n_errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+logic
logic/am_rx_pkg.sv
logic/iq_dispatch.sv
logic/am_demod_lite.sv
logic/demod_collector.sv
logic/am_rx_top.sv
tb/am_rx_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = am_rx_tb
FILELIST  = list.f
PASS_MSG  = *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
